// File: project.f
soc_pkg.sv
bus_arbiter.sv
bus_decoder.sv
word_ram.sv
uart_tx.sv
soc_top.sv
tb_soc.sv

// File: Bender.yml
package:
  name: soc_bus

sources:
  - soc_pkg.sv
  - bus_arbiter.sv
  - bus_decoder.sv
  - word_ram.sv
  - uart_tx.sv
  - soc_top.sv
  - target: simulation
    files:
      - tb_soc.sv

// File: tb_soc.sv
module tb_soc import soc_pkg::*;;

    localparam int unsigned RAM_WORDS    = 64;
    localparam logic [31:0] SYS_CLK_HZ   = 32'd12_000_000;
    localparam int unsigned CLKS_PER_BIT = 8;
    localparam int unsigned AW           = $clog2(RAM_WORDS);
    localparam int          N_RAND       = 40;
    // valid to ready of a uart write through the stop bit
    localparam int          FRAME_CYC    = 2 + 10 * CLKS_PER_BIT;
    // each short access at worst waits out the other port plus three frames
    localparam int          MAX_CYCLES   = 2 * ((RAM_WORDS + 80) * 6 + 3 * (FRAME_CYC + 6));

    logic        clk;
    logic        arst_n;
    logic        imem_valid;
    logic        dmem_valid;
    logic        imem_ready;
    logic        dmem_ready;
    logic        txd;
    bus_req_t    imem_req;
    bus_req_t    dmem_req;
    bus_rsp_t    mem_rsp;
    logic [31:0] model [RAM_WORDS];
    logic [31:0] lfsr;
    int          val_errs;
    int          oth_errs;
    int          cycles;

    soc_top #(
        .RAM_WORDS    (RAM_WORDS),
        .SYS_CLK_HZ   (SYS_CLK_HZ),
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) i_dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .imem_valid (imem_valid),
        .imem_req   (imem_req),
        .imem_ready (imem_ready),
        .dmem_valid (dmem_valid),
        .dmem_req   (dmem_req),
        .dmem_ready (dmem_ready),
        .mem_rsp    (mem_rsp),
        .txd        (txd)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    // fibonacci lfsr with taps 32 22 2 1 and one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return addr ^ {addr[15:0], addr[31:16]} ^ 32'h9e37_79b9;
    endfunction

    function automatic int widx(input logic [31:0] addr);
        return (addr >> 2) % RAM_WORDS;
    endfunction

    task automatic check_rsp(input string name, input bus_rsp_t got, input bus_rsp_t exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %h expected %h", $time, name, got.rdata, exp.rdata);
            val_errs++;
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            val_errs++;
        end
    endtask

    task automatic check_lat(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("%0t: %s got ready %0d cycles after valid instead of %0d",
                     $time, what, got, exp);
            oth_errs++;
        end
    endtask

    // one access on a master port with valid held until ready
    task automatic access(input master_idx_t port, input bus_req_t req,
                          output bus_rsp_t rsp, output int lat);
        logic rdy;
        @(negedge clk);
        if (port == MST_IMEM) begin
            imem_req   = req;
            imem_valid = 1'b1;
        end else begin
            dmem_req   = req;
            dmem_valid = 1'b1;
        end
        lat = 0;
        rdy = 1'b0;
        while (!rdy) begin
            @(negedge clk);
            lat++;
            rdy = (port == MST_IMEM) ? imem_ready : dmem_ready;
        end
        rsp = mem_rsp;
        if (port == MST_IMEM) begin
            imem_valid = 1'b0;
        end else begin
            dmem_valid = 1'b0;
        end
    endtask

    task automatic write_only(input master_idx_t port, input logic [31:0] addr,
                              input logic [31:0] data, input logic [3:0] strb, input int exp_lat);
        bus_rsp_t rsp;
        int       lat;
        access(port, '{addr: addr, wdata: data, wstrb: strb}, rsp, lat);
        check_lat("write", lat, exp_lat);
    endtask

    task automatic read_check(input master_idx_t port, input logic [31:0] addr,
                              input bus_rsp_t exp, input int exp_lat);
        bus_rsp_t rsp;
        int       lat;
        access(port, '{addr: addr, wdata: 32'h0, wstrb: 4'h0}, rsp, lat);
        check_lat("read", lat, exp_lat);
        check_rsp(port == MST_IMEM ? "imem mem_rsp" : "dmem mem_rsp", rsp, exp);
    endtask

    task automatic ram_write(input master_idx_t port, input logic [31:0] addr,
                             input logic [31:0] data, input logic [3:0] strb, input int exp_lat);
        write_only(port, addr, data, strb, exp_lat);
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                model[widx(addr)][8*i +: 8] = data[8*i +: 8];
            end
        end
    endtask

    task automatic ram_read(input master_idx_t port, input logic [31:0] addr, input int exp_lat);
        read_check(port, addr, bus_rsp_t'(model[widx(addr)]), exp_lat);
    endtask

    // samples txd at bit centers
    task automatic watch_frame(input logic [7:0] exp);
        logic [7:0] got;
        @(negedge txd);
        repeat (CLKS_PER_BIT / 2) @(negedge clk);
        if (txd !== 1'b0) begin
            $display("%0t: start bit on txd is not low", $time);
            oth_errs++;
        end
        for (int i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            got[i] = txd;
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        if (txd !== 1'b1) begin
            $display("%0t: stop bit on txd is not high", $time);
            oth_errs++;
        end
        check_byte("txd byte", got, exp);
    endtask

    task automatic uart_write(input master_idx_t port, input logic [31:0] data);
        fork
            write_only(port, UART_TX_ADDR, data, 4'h1, FRAME_CYC);
            watch_frame(data[7:0]);
        join
    endtask

    task automatic test_arbitration();
        // first tie after reset goes to imem
        fork
            ram_write(MST_IMEM, 32'h20, 32'hcafe_0001, 4'hf, 2);
            ram_write(MST_DMEM, 32'h24, 32'hcafe_0002, 4'hf, 5);
        join
        fork
            ram_read(MST_IMEM, 32'h24, 2);
            ram_read(MST_DMEM, 32'h20, 5);
        join
        // imem served last so dmem wins this tie
        ram_read(MST_IMEM, 32'h20, 2);
        fork
            ram_read(MST_IMEM, 32'h20, 5);
            ram_read(MST_DMEM, 32'h24, 2);
        join
        // imem waits behind the frame and one idle cycle before its own two
        fork
            uart_write(MST_DMEM, 32'h0000_0071);
            begin
                repeat (5) @(negedge clk);
                ram_read(MST_IMEM, 32'h20, FRAME_CYC + 3 - 5);
            end
        join
    endtask

    task automatic test_ram_bytes();
        ram_write(MST_IMEM, 32'h40, 32'h1122_3344, 4'hf, 2);
        ram_write(MST_DMEM, 32'h44, 32'h5566_7788, 4'hf, 2);
        ram_write(MST_IMEM, 32'h40, 32'haabb_ccdd, 4'b0001, 2);
        ram_write(MST_DMEM, 32'h40, 32'h0099_0000, 4'b0100, 2);
        ram_write(MST_DMEM, 32'h44, 32'hffee_ddcc, 4'b0011, 2);
        ram_write(MST_IMEM, 32'h44, 32'h1234_5678, 4'b1100, 2);
        ram_write(MST_IMEM, 32'h48, 32'h0f0f_0f0f, 4'b1000, 2);
        for (int a = 32'h40; a <= 32'h48; a += 4) begin
            ram_read(MST_IMEM, a, 2);
            ram_read(MST_DMEM, a, 2);
        end
    endtask

    task automatic test_sysinfo();
        read_check(MST_IMEM, SYSINFO_ADDR, bus_rsp_t'(SYS_CLK_HZ), 2);
        write_only(MST_DMEM, SYSINFO_ADDR, 32'h0000_0001, 4'hf, 2);
        read_check(MST_DMEM, SYSINFO_ADDR, bus_rsp_t'(SYS_CLK_HZ), 2);
    endtask

    task automatic test_uart();
        uart_write(MST_DMEM, 32'h0000_01a5);
        uart_write(MST_IMEM, 32'hffff_ff5a);
        // status read reports the transmitter ready
        read_check(MST_DMEM, UART_TX_ADDR, bus_rsp_t'(32'hffff_ffff), 2);
    endtask

    task automatic test_unmapped();
        read_check(MST_DMEM, 32'h2000_0000, '0, 2);
        read_check(MST_IMEM, 32'h1000_0008, '0, 2);
        write_only(MST_IMEM, 32'h2000_0000, 32'hdead_beef, 4'hf, 2);
        read_check(MST_IMEM, 32'h2000_0000, '0, 2);
        ram_read(MST_DMEM, 32'h0, 2);
    endtask

    task automatic test_random();
        master_idx_t port;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic        wr;
        for (int n = 0; n < N_RAND; n++) begin
            port = master_idx_t'(take_bits(1));
            addr = take_bits(AW) << 2;
            wr   = 1'(take_bits(1));
            data = take_bits(32);
            strb = 4'(take_bits(4));
            if (wr && strb != 4'h0) begin
                ram_write(port, addr, data, strb, 2);
            end else begin
                ram_read(port, addr, 2);
            end
        end
    endtask

    initial begin
        clk        = 1'b0;
        arst_n     = 1'b0;
        imem_valid = 1'b0;
        dmem_valid = 1'b0;
        imem_req   = '0;
        dmem_req   = '0;
        lfsr       = 32'h4fc7_2099;
        val_errs   = 0;
        oth_errs   = 0;
        cycles     = 0;
        repeat (2) @(negedge clk);
        if (imem_ready !== 1'b0 || dmem_ready !== 1'b0 || txd !== 1'b1) begin
            $display("%0t: ready or txd not at idle level during reset", $time);
            oth_errs++;
        end
        arst_n = 1'b1;
        test_arbitration();
        for (int i = 0; i < RAM_WORDS; i++) begin
            ram_write(master_idx_t'(i[0]), i * 4, fill_word(i * 4), 4'hf, 2);
        end
        test_ram_bytes();
        test_sysinfo();
        test_uart();
        test_unmapped();
        test_random();
        $display("value errors: %0d, other errors: %0d", val_errs, oth_errs);
        if (val_errs + oth_errs == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: soc_top.sv
module soc_top import soc_pkg::*; #(
    parameter int unsigned RAM_WORDS    = 256,
    parameter logic [31:0] SYS_CLK_HZ   = 32'd1_000_000,
    parameter int unsigned CLKS_PER_BIT = 8
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     imem_valid,
    input  bus_req_t imem_req,
    output logic     imem_ready,
    input  logic     dmem_valid,
    input  bus_req_t dmem_req,
    output logic     dmem_ready,
    output bus_rsp_t mem_rsp,
    output logic     txd
);

    logic [1:0]     m_valid;
    logic [1:0]     m_ready;
    bus_req_t [1:0] m_req;
    logic           bus_valid;
    bus_req_t       bus_req;
    logic           bus_ready;
    bus_rsp_t       bus_rsp;
    logic           ram_valid;
    logic           ram_ready;
    bus_rsp_t       ram_rsp;
    logic           uart_valid;
    logic           uart_ready;
    bus_rsp_t       uart_rsp;

    // master ports in arbiter order
    assign m_valid[MST_IMEM] = imem_valid;
    assign m_valid[MST_DMEM] = dmem_valid;
    assign m_req[MST_IMEM]   = imem_req;
    assign m_req[MST_DMEM]   = dmem_req;
    assign imem_ready        = m_ready[MST_IMEM];
    assign dmem_ready        = m_ready[MST_DMEM];

    bus_arbiter i_arbiter (
        .clk       (clk),
        .arst_n    (arst_n),
        .m_valid   (m_valid),
        .m_req     (m_req),
        .m_ready   (m_ready),
        .m_rsp     (mem_rsp),
        .bus_valid (bus_valid),
        .bus_req   (bus_req),
        .bus_ready (bus_ready),
        .bus_rsp   (bus_rsp)
    );

    bus_decoder #(
        .RAM_WORDS  (RAM_WORDS),
        .SYS_CLK_HZ (SYS_CLK_HZ)
    ) i_decoder (
        .clk        (clk),
        .arst_n     (arst_n),
        .bus_valid  (bus_valid),
        .bus_req    (bus_req),
        .bus_ready  (bus_ready),
        .bus_rsp    (bus_rsp),
        .ram_valid  (ram_valid),
        .ram_ready  (ram_ready),
        .ram_rsp    (ram_rsp),
        .uart_valid (uart_valid),
        .uart_ready (uart_ready),
        .uart_rsp   (uart_rsp)
    );

    word_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) i_ram (
        .clk    (clk),
        .arst_n (arst_n),
        .valid  (ram_valid),
        .req    (bus_req),
        .ready  (ram_ready),
        .rsp    (ram_rsp)
    );

    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) i_uart (
        .clk    (clk),
        .arst_n (arst_n),
        .valid  (uart_valid),
        .req    (bus_req),
        .ready  (uart_ready),
        .rsp    (uart_rsp),
        .txd    (txd)
    );

endmodule

// File: uart_tx.sv
module uart_tx import soc_pkg::*; #(
    parameter int unsigned CLKS_PER_BIT = 8
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     valid,
    input  bus_req_t req,
    output logic     ready,
    output bus_rsp_t rsp,
    output logic     txd
);

    localparam int unsigned    CNT_W    = $clog2(CLKS_PER_BIT + 1);
    localparam logic [CNT_W-1:0] LAST_CLK = CNT_W'(CLKS_PER_BIT - 1);

    logic             busy;
    logic             load;
    logic             bit_end;
    logic [3:0]       bit_cnt;
    logic [CNT_W-1:0] clk_cnt;
    // data bits then stop bit, shifted out lsb first
    logic [8:0]       shifter;

    assign load    = valid && !busy && req_is_write(req);
    assign bit_end = clk_cnt == LAST_CLK;

    // status reads always see the transmitter as ready
    assign rsp.rdata = '1;

    always_ff @(posedge clk) begin
        if (load) begin
            shifter <= {1'b1, req.wdata[7:0]};
        end else if (busy && bit_end) begin
            shifter <= shifter >> 1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy    <= 1'b0;
            ready   <= 1'b0;
            txd     <= 1'b1;
            bit_cnt <= 4'd0;
            clk_cnt <= '0;
        end else begin
            ready <= 1'b0;
            if (!busy) begin
                if (load) begin
                    // start bit from the next cycle on
                    busy    <= 1'b1;
                    txd     <= 1'b0;
                    bit_cnt <= 4'd0;
                    clk_cnt <= '0;
                end else if (valid) begin
                    ready <= 1'b1;
                end
            end else if (bit_end) begin
                clk_cnt <= '0;
                if (bit_cnt == 4'd9) begin
                    // stop bit done, complete the write
                    busy  <= 1'b0;
                    ready <= 1'b1;
                    txd   <= 1'b1;
                end else begin
                    txd     <= shifter[0];
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end
        end
    end

endmodule

// File: word_ram.sv
module word_ram import soc_pkg::*; #(
    parameter int unsigned RAM_WORDS = 256
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     valid,
    input  bus_req_t req,
    output logic     ready,
    output bus_rsp_t rsp
);

    localparam int unsigned AW = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

    logic [31:0]   mem [RAM_WORDS];
    logic [AW-1:0] idx;

    // word address, the decoder keeps it inside the ram window
    assign idx = req.addr[AW+1:2];

    always_ff @(posedge clk) begin
        if (valid) begin
            if (req_is_write(req)) begin
                // merge only the strobed bytes
                for (int i = 0; i < 4; i++) begin
                    if (req.wstrb[i]) begin
                        mem[idx][8*i +: 8] <= req.wdata[8*i +: 8];
                    end
                end
            end else begin
                rsp.rdata <= mem[idx];
            end
        end
    end

    // ready one cycle after the strobe
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ready <= 1'b0;
        end else begin
            ready <= valid;
        end
    end

endmodule

// File: bus_decoder.sv
module bus_decoder import soc_pkg::*; #(
    parameter int unsigned RAM_WORDS  = 256,
    parameter logic [31:0] SYS_CLK_HZ = 32'd1_000_000
) (
    input  logic     clk,
    input  logic     arst_n,

    input  logic     bus_valid,
    input  bus_req_t bus_req,
    output logic     bus_ready,
    output bus_rsp_t bus_rsp,

    output logic     ram_valid,
    input  logic     ram_ready,
    input  bus_rsp_t ram_rsp,

    output logic     uart_valid,
    input  logic     uart_ready,
    input  bus_rsp_t uart_rsp
);

    localparam logic [31:0] RAM_BYTES = 32'(RAM_WORDS * 4);

    logic     sel_ram;
    logic     sel_uart;
    logic     sel_sys;
    logic     sel_none;
    logic     loc_strobe;
    logic     loc_ready;
    logic     pending;
    bus_rsp_t loc_rsp;

    // offset compare covers the whole ram window
    assign sel_ram  = (bus_req.addr - RAM_BASE) < RAM_BYTES;
    assign sel_uart = bus_req.addr == UART_TX_ADDR;
    assign sel_sys  = bus_req.addr == SYSINFO_ADDR;
    assign sel_none = !(sel_ram || sel_uart || sel_sys);

    // one strobe per access
    assign ram_valid  = bus_valid && sel_ram && !ram_ready && !pending;
    assign uart_valid = bus_valid && sel_uart && !uart_ready && !pending;
    // sysinfo and unmapped share the local responder
    assign loc_strobe = bus_valid && (sel_sys || sel_none) && !loc_ready && !pending;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pending   <= 1'b0;
            loc_ready <= 1'b0;
        end else begin
            loc_ready <= loc_strobe;
            if (bus_ready) begin
                pending <= 1'b0;
            end else if (ram_valid || uart_valid || loc_strobe) begin
                pending <= 1'b1;
            end
        end
    end

    // clock frequency on sysinfo reads, zero otherwise
    always_ff @(posedge clk) begin
        if (loc_strobe) begin
            loc_rsp.rdata <= (sel_sys && !req_is_write(bus_req)) ? SYS_CLK_HZ : 32'h0;
        end
    end

    assign bus_ready = ram_ready || uart_ready || loc_ready;
    assign bus_rsp   = ram_ready  ? ram_rsp  :
                       uart_ready ? uart_rsp :
                       loc_rsp;

endmodule

// File: bus_arbiter.sv
module bus_arbiter import soc_pkg::*; (
    input  logic           clk,
    input  logic           arst_n,

    // master side
    input  logic [1:0]     m_valid,
    input  bus_req_t [1:0] m_req,
    output logic [1:0]     m_ready,
    output bus_rsp_t       m_rsp,

    // shared bus towards the decoder
    output logic           bus_valid,
    output bus_req_t       bus_req,
    input  logic           bus_ready,
    input  bus_rsp_t       bus_rsp
);

    logic        busy;
    master_idx_t grant;
    master_idx_t last;
    master_idx_t pick;

    // round robin pick, the master not served last wins a tie
    always_comb begin
        if (m_valid[0] && m_valid[1]) begin
            pick = ~last;
        end else if (m_valid[MST_DMEM]) begin
            pick = MST_DMEM;
        end else begin
            pick = MST_IMEM;
        end
    end

    // grant is locked from the sampled valid until bus_ready,
    // then the bus stays idle for one cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy  <= 1'b0;
            grant <= MST_IMEM;
            // so that master 0 wins the first tie
            last  <= MST_DMEM;
        end else begin
            if (busy) begin
                if (bus_ready) begin
                    busy <= 1'b0;
                end
            end else if (|m_valid) begin
                busy  <= 1'b1;
                grant <= pick;
                last  <= pick;
            end
        end
    end

    assign bus_valid = busy;
    assign bus_req   = m_req[grant];

    // ready only to the granted master, data to both
    assign m_ready[MST_IMEM] = busy && bus_ready && (grant == MST_IMEM);
    assign m_ready[MST_DMEM] = busy && bus_ready && (grant == MST_DMEM);
    assign m_rsp             = bus_rsp;

endmodule

// File: soc_pkg.sv
package soc_pkg;

    // one bus access as driven by a master
    // wstrb all clear means a read
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
    } bus_req_t;

    // response payload, valid in the ready cycle
    typedef struct packed {
        logic [31:0] rdata;
    } bus_rsp_t;

    // master index, 0 is the instruction port and 1 the data port
    typedef logic master_idx_t;

    localparam master_idx_t MST_IMEM = 1'b0;
    localparam master_idx_t MST_DMEM = 1'b1;

    // address map
    localparam logic [31:0] RAM_BASE     = 32'h0000_0000;
    localparam logic [31:0] UART_TX_ADDR = 32'h1000_0000;
    localparam logic [31:0] SYSINFO_ADDR = 32'h1000_0004;

    // any set byte strobe turns the access into a write
    function automatic logic req_is_write(input bus_req_t req);
        return |req.wstrb;
    endfunction

endpackage
